// ==== design/udp_pkg.sv ====
//////////////////////////////
// udp checksum package
// widths, field types and the payload beat view shared by the design
//////////////////////////////

`default_nettype none

package udp_pkg;

    localparam int DATA_BYTES       = 8;
    localparam int LANE_COUNT       = 4;
    localparam int UDP_HEADER_BYTES = 8;

    localparam logic [7:0] UDP_PROTOCOL = 8'd17;

    typedef logic [15:0] word_t;
    typedef logic [31:0] sum_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [DATA_BYTES-1:0] keep_t;

    // word k covers bytes 2k (low half) and 2k+1 (high half)
    typedef union packed {
        logic [DATA_BYTES*8-1:0] data;
        word_t [LANE_COUNT-1:0]  words;
    } payload_beat_u;

endpackage

`default_nettype wire

// ==== design/udp_ifs.sv ====
//////////////////////////////
// udp checksum interfaces
// beat_if feeds the lanes, frame_if carries frame data to the folder
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface beat_if
    import udp_pkg::*;
();

    payload_beat_u beat;
    keep_t         keep;
    logic          accept;
    // start of a new frame
    logic          clear;

    modport ctrl (output beat, output keep, output accept, output clear);
    modport lane (input beat, input keep, input accept, input clear);

endinterface

interface frame_if
    import udp_pkg::*;
();

    ip_addr_t source_ip;
    ip_addr_t dest_ip;
    port_t    source_port;
    port_t    dest_port;
    port_t    udp_length;
    logic     frame_end;
    logic     done;

    modport ctrl (
        output source_ip, output dest_ip, output source_port, output dest_port,
        output udp_length, output frame_end,
        input  done
    );

    modport fold (
        input  source_ip, input dest_ip, input source_port, input dest_port,
        input  udp_length, input frame_end,
        output done
    );

endinterface

`default_nettype wire

// ==== design/udp_lane_sum.sv ====
//////////////////////////////
// udp lane accumulator
// sums one 16-bit word of every payload beat
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_lane_sum
    import udp_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic   clk,
    input  logic   rst,
    beat_if.lane   beat,
    output sum_t   lane_sum
);

    word_t raw;
    word_t word;

    assign raw = beat.beat.words[LANE];

    // network order, byte 2*LANE is the high byte; missing bytes pad with zero
    assign word = {beat.keep[2*LANE]   ? raw[7:0]  : 8'h00,
                   beat.keep[2*LANE+1] ? raw[15:8] : 8'h00};

    always_ff @(posedge clk) begin
        if (rst || beat.clear) begin
            lane_sum <= '0;
        end else if (beat.accept) begin
            lane_sum <= lane_sum + sum_t'(word);
        end
    end

endmodule

`default_nettype wire

// ==== design/udp_checksum_fold.sv ====
//////////////////////////////
// udp checksum folder
// adds pseudo header and lane sums, folds, inverts, writes header FIFO
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_checksum_fold
    import udp_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    frame_if.fold                 frame,
    input  sum_t [LANE_COUNT-1:0] lane_sums,

    output logic                  hdr_wr,
    output ip_addr_t              hdr_source_ip,
    output ip_addr_t              hdr_dest_ip,
    output port_t                 hdr_source_port,
    output port_t                 hdr_dest_port,
    output port_t                 hdr_udp_length,
    output word_t                 hdr_checksum
);

    sum_t        total;
    sum_t        total_reg;
    logic        sum_valid;
    logic [16:0] partial;

    // length counts twice, once in the pseudo header and once in the udp header
    always_comb begin
        total = sum_t'(UDP_PROTOCOL)
              + sum_t'({frame.udp_length, 1'b0})
              + sum_t'(frame.source_ip[31:16]) + sum_t'(frame.source_ip[15:0])
              + sum_t'(frame.dest_ip[31:16])   + sum_t'(frame.dest_ip[15:0])
              + sum_t'(frame.source_port)      + sum_t'(frame.dest_port);
        for (int i = 0; i < LANE_COUNT; i++) begin
            total = total + lane_sums[i];
        end
    end

    assign partial = {1'b0, total_reg[15:0]} + {1'b0, total_reg[31:16]};

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
            hdr_wr    <= 1'b0;
        end else begin
            sum_valid <= frame.frame_end;
            hdr_wr    <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (frame.frame_end) begin
            total_reg       <= total;
            hdr_source_ip   <= frame.source_ip;
            hdr_dest_ip     <= frame.dest_ip;
            hdr_source_port <= frame.source_port;
            hdr_dest_port   <= frame.dest_port;
            hdr_udp_length  <= frame.udp_length;
        end
        // end-around carry, a zero result stays zero
        if (sum_valid) begin
            hdr_checksum <= ~(partial[15:0] + word_t'(partial[16]));
        end
    end

    assign frame.done = hdr_wr;

endmodule

`default_nettype wire

// ==== design/udp_frame_ctrl.sv ====
//////////////////////////////
// udp frame controller
// takes headers, gates payload beats into the FIFO and counts length
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_frame_ctrl
    import udp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_hdr_valid,
    output logic                    in_hdr_ready,
    input  ip_addr_t                in_source_ip,
    input  ip_addr_t                in_dest_ip,
    input  port_t                   in_source_port,
    input  port_t                   in_dest_port,

    input  logic [DATA_BYTES*8-1:0] in_tdata,
    input  keep_t                   in_tkeep,
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic                    in_tlast,

    output logic                    fifo_wr,
    input  logic                    fifo_full,
    input  logic                    hdr_fifo_full,

    beat_if.ctrl                    beat,
    frame_if.ctrl                   frame,

    output logic                    busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_WAIT
    } state_t;

    state_t                          state;
    // holds header ready low for the first cycle out of reset
    logic                            armed;
    logic                            hdr_accept;
    logic                            beat_accept;
    logic [$clog2(DATA_BYTES+1)-1:0] byte_count;

    assign in_hdr_ready = armed && (state == ST_IDLE) && !hdr_fifo_full;
    assign in_tready    = (state == ST_PAYLOAD) && !fifo_full;
    assign hdr_accept   = in_hdr_valid && in_hdr_ready;
    assign beat_accept  = in_tvalid && in_tready;
    assign fifo_wr      = beat_accept;
    assign busy         = state != ST_IDLE;

    assign beat.beat.data = in_tdata;
    assign beat.keep      = in_tkeep;
    assign beat.accept    = beat_accept;
    assign beat.clear     = hdr_accept;

    // keep is contiguous, so the set bits give the byte count
    always_comb begin
        byte_count = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            byte_count = byte_count + in_tkeep[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            armed           <= 1'b0;
            frame.frame_end <= 1'b0;
        end else begin
            armed           <= 1'b1;
            frame.frame_end <= beat_accept && in_tlast;
            case (state)
                ST_IDLE: begin
                    if (hdr_accept) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_accept && in_tlast) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // folder has written the header
                    if (frame.done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            frame.source_ip   <= in_source_ip;
            frame.dest_ip     <= in_dest_ip;
            frame.source_port <= in_source_port;
            frame.dest_port   <= in_dest_port;
            frame.udp_length  <= port_t'(UDP_HEADER_BYTES);
        end else if (beat_accept) begin
            frame.udp_length  <= frame.udp_length + port_t'(byte_count);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        beat_accept |-> (in_tkeep != '0) && ((in_tkeep & (in_tkeep + 1'b1)) == '0))
        else $error("payload keep is empty or not contiguous from byte 0");

endmodule

`default_nettype wire

// ==== design/udp_header_fifo.sv ====
//////////////////////////////
// udp header FIFO
// completed headers with a registered valid/ready output
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_header_fifo
    import udp_pkg::*;
#(
    parameter int HEADER_FIFO_ADDR_WIDTH = 2
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     wr,
    input  ip_addr_t wr_source_ip,
    input  ip_addr_t wr_dest_ip,
    input  port_t    wr_source_port,
    input  port_t    wr_dest_port,
    input  port_t    wr_udp_length,
    input  word_t    wr_checksum,
    output logic     full,

    output logic     out_hdr_valid,
    input  logic     out_hdr_ready,
    output ip_addr_t out_source_ip,
    output ip_addr_t out_dest_ip,
    output port_t    out_source_port,
    output port_t    out_dest_port,
    output port_t    out_udp_length,
    output word_t    out_udp_checksum
);

    localparam int AW         = HEADER_FIFO_ADDR_WIDTH;
    localparam int ENTRY_BITS = 2 * $bits(ip_addr_t) + 3 * $bits(port_t) + $bits(word_t);

    logic [ENTRY_BITS-1:0] mem [2**AW];
    // extra top bit tells full from empty
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic                  empty;
    logic                  rd;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    // reload the output register when it is empty or being taken
    assign rd    = !empty && (out_hdr_ready || !out_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            out_hdr_valid <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_hdr_ready || !out_hdr_valid) begin
                out_hdr_valid <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[AW-1:0]] <= {wr_source_ip, wr_dest_ip, wr_source_port,
                                    wr_dest_port, wr_udp_length, wr_checksum};
        end
        if (rd) begin
            {out_source_ip, out_dest_ip, out_source_port,
             out_dest_port, out_udp_length, out_udp_checksum} <= mem[rd_ptr[AW-1:0]];
        end
    end

    // the controller only takes a header while there is room for it
    assert property (@(posedge clk) disable iff (rst) wr |-> !full)
        else $error("header FIFO written while full");

endmodule

`default_nettype wire

// ==== design/udp_payload_fifo.sv ====
//////////////////////////////
// udp payload FIFO
// payload beats with keep and last, registered output
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_payload_fifo
    import udp_pkg::*;
#(
    parameter int PAYLOAD_FIFO_ADDR_WIDTH = 5
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    wr,
    input  logic [DATA_BYTES*8-1:0] wr_data,
    input  keep_t                   wr_keep,
    input  logic                    wr_last,
    output logic                    full,

    output logic [DATA_BYTES*8-1:0] out_tdata,
    output keep_t                   out_tkeep,
    output logic                    out_tvalid,
    output logic                    out_tlast,
    input  logic                    out_tready
);

    localparam int AW         = PAYLOAD_FIFO_ADDR_WIDTH;
    localparam int ENTRY_BITS = DATA_BYTES * 8 + $bits(keep_t) + 1;

    logic [ENTRY_BITS-1:0] mem [2**AW];
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic                  empty;
    logic                  rd;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rd    = !empty && (out_tready || !out_tvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_tready || !out_tvalid) begin
                out_tvalid <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[AW-1:0]] <= {wr_last, wr_keep, wr_data};
        end
        if (rd) begin
            {out_tlast, out_tkeep, out_tdata} <= mem[rd_ptr[AW-1:0]];
        end
    end

    // in_tready is gated by full, so an overflow means a broken handshake upstream
    assert property (@(posedge clk) disable iff (rst) wr |-> !full)
        else $error("payload FIFO written while full");

endmodule

`default_nettype wire

// ==== design/udp_checksum_top.sv ====
//////////////////////////////
// udp checksum top
// length and checksum generator with header and payload FIFOs
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_checksum_top
    import udp_pkg::*;
#(
    parameter int PAYLOAD_FIFO_ADDR_WIDTH = 5,
    parameter int HEADER_FIFO_ADDR_WIDTH  = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    busy,

    input  logic                    in_hdr_valid,
    output logic                    in_hdr_ready,
    input  ip_addr_t                in_source_ip,
    input  ip_addr_t                in_dest_ip,
    input  port_t                   in_source_port,
    input  port_t                   in_dest_port,

    input  logic [DATA_BYTES*8-1:0] in_tdata,
    input  keep_t                   in_tkeep,
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic                    in_tlast,

    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output ip_addr_t                out_source_ip,
    output ip_addr_t                out_dest_ip,
    output port_t                   out_source_port,
    output port_t                   out_dest_port,
    output port_t                   out_udp_length,
    output word_t                   out_udp_checksum,

    output logic [DATA_BYTES*8-1:0] out_tdata,
    output keep_t                   out_tkeep,
    output logic                    out_tvalid,
    output logic                    out_tlast,
    input  logic                    out_tready
);

    logic                    payload_wr;
    logic                    payload_full;
    logic                    hdr_full;
    logic                    hdr_wr;
    ip_addr_t                hdr_source_ip;
    ip_addr_t                hdr_dest_ip;
    port_t                   hdr_source_port;
    port_t                   hdr_dest_port;
    port_t                   hdr_udp_length;
    word_t                   hdr_checksum;
    sum_t [LANE_COUNT-1:0]   lane_sums;

    beat_if  beat_bus ();
    frame_if frame_bus ();

    udp_frame_ctrl frame_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .in_hdr_valid   (in_hdr_valid),
        .in_hdr_ready   (in_hdr_ready),
        .in_source_ip   (in_source_ip),
        .in_dest_ip     (in_dest_ip),
        .in_source_port (in_source_port),
        .in_dest_port   (in_dest_port),
        .in_tdata       (in_tdata),
        .in_tkeep       (in_tkeep),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .fifo_wr        (payload_wr),
        .fifo_full      (payload_full),
        .hdr_fifo_full  (hdr_full),
        .beat           (beat_bus),
        .frame          (frame_bus),
        .busy           (busy)
    );

    // one accumulator per 16-bit word of the beat
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        udp_lane_sum #(
            .LANE (i)
        ) lane_sum_i (
            .clk      (clk),
            .rst      (rst),
            .beat     (beat_bus),
            .lane_sum (lane_sums[i])
        );
    end

    udp_checksum_fold checksum_fold_i (
        .clk             (clk),
        .rst             (rst),
        .frame           (frame_bus),
        .lane_sums       (lane_sums),
        .hdr_wr          (hdr_wr),
        .hdr_source_ip   (hdr_source_ip),
        .hdr_dest_ip     (hdr_dest_ip),
        .hdr_source_port (hdr_source_port),
        .hdr_dest_port   (hdr_dest_port),
        .hdr_udp_length  (hdr_udp_length),
        .hdr_checksum    (hdr_checksum)
    );

    udp_header_fifo #(
        .HEADER_FIFO_ADDR_WIDTH (HEADER_FIFO_ADDR_WIDTH)
    ) header_fifo_i (
        .clk              (clk),
        .rst              (rst),
        .wr               (hdr_wr),
        .wr_source_ip     (hdr_source_ip),
        .wr_dest_ip       (hdr_dest_ip),
        .wr_source_port   (hdr_source_port),
        .wr_dest_port     (hdr_dest_port),
        .wr_udp_length    (hdr_udp_length),
        .wr_checksum      (hdr_checksum),
        .full             (hdr_full),
        .out_hdr_valid    (out_hdr_valid),
        .out_hdr_ready    (out_hdr_ready),
        .out_source_ip    (out_source_ip),
        .out_dest_ip      (out_dest_ip),
        .out_source_port  (out_source_port),
        .out_dest_port    (out_dest_port),
        .out_udp_length   (out_udp_length),
        .out_udp_checksum (out_udp_checksum)
    );

    udp_payload_fifo #(
        .PAYLOAD_FIFO_ADDR_WIDTH (PAYLOAD_FIFO_ADDR_WIDTH)
    ) payload_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .wr         (payload_wr),
        .wr_data    (in_tdata),
        .wr_keep    (in_tkeep),
        .wr_last    (in_tlast),
        .full       (payload_full),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tready (out_tready)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_udp_checksum.sv ====
//////////////////////////////
// udp checksum testbench
// random frames checked against a reference checksum model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_udp_checksum
    import udp_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_FRAMES      = 40;
    localparam int MAX_LEN         = 40;
    // four FIFO entries plus the registered output stage
    localparam int HDR_CAPACITY    = 5;
    localparam int HOLD_FIRST      = 15;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (6 + 20) * 4;

    typedef struct packed {
        ip_addr_t source_ip;
        ip_addr_t dest_ip;
        port_t    source_port;
        port_t    dest_port;
        port_t    udp_length;
        word_t    checksum;
    } hdr_t;

    typedef struct packed {
        logic                    last;
        keep_t                   keep;
        logic [DATA_BYTES*8-1:0] data;
    } beat_t;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    busy;
    logic                    in_hdr_valid;
    logic                    in_hdr_ready;
    ip_addr_t                in_source_ip;
    ip_addr_t                in_dest_ip;
    port_t                   in_source_port;
    port_t                   in_dest_port;
    logic [DATA_BYTES*8-1:0] in_tdata;
    keep_t                   in_tkeep;
    logic                    in_tvalid;
    logic                    in_tready;
    logic                    in_tlast;
    logic                    out_hdr_valid;
    logic                    out_hdr_ready;
    ip_addr_t                out_source_ip;
    ip_addr_t                out_dest_ip;
    port_t                   out_source_port;
    port_t                   out_dest_port;
    port_t                   out_udp_length;
    word_t                   out_udp_checksum;
    logic [DATA_BYTES*8-1:0] out_tdata;
    keep_t                   out_tkeep;
    logic                    out_tvalid;
    logic                    out_tlast;
    logic                    out_tready;

    hdr_t  exp_hdr_q[$];
    beat_t beat_q[$];
    int    frame_beats [NUM_FRAMES];
    hdr_t  exp_hdr;
    beat_t exp_beat;
    int    hdr_count   = 0;
    int    beat_count  = 0;
    int    next_beat   = 0;
    int    hdr_errors  = 0;
    int    beat_errors = 0;
    int    ctrl_errors = 0;
    logic  hold_hdr    = 1'b0;

    udp_checksum_top udp_checksum_top_i (
        .clk              (clk),
        .rst              (rst),
        .busy             (busy),
        .in_hdr_valid     (in_hdr_valid),
        .in_hdr_ready     (in_hdr_ready),
        .in_source_ip     (in_source_ip),
        .in_dest_ip       (in_dest_ip),
        .in_source_port   (in_source_port),
        .in_dest_port     (in_dest_port),
        .in_tdata         (in_tdata),
        .in_tkeep         (in_tkeep),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tlast         (in_tlast),
        .out_hdr_valid    (out_hdr_valid),
        .out_hdr_ready    (out_hdr_ready),
        .out_source_ip    (out_source_ip),
        .out_dest_ip      (out_dest_ip),
        .out_source_port  (out_source_port),
        .out_dest_port    (out_dest_port),
        .out_udp_length   (out_udp_length),
        .out_udp_checksum (out_udp_checksum),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tvalid       (out_tvalid),
        .out_tlast        (out_tlast),
        .out_tready       (out_tready)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic hdr_t header_at(input int idx);
        if (idx < exp_hdr_q.size()) begin
            return exp_hdr_q[idx];
        end
        return '0;
    endfunction

    function automatic beat_t beat_at(input int idx);
        if (idx < beat_q.size()) begin
            return beat_q[idx];
        end
        return '0;
    endfunction

    // reference model of the one's complement sum over pseudo header, udp header and payload
    task automatic build_frames();
        logic [7:0]  payload [MAX_LEN];
        logic [31:0] sum;
        hdr_t        hdr;
        beat_t       beat;
        int          len;
        int          remaining;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len             = f + 1;
            hdr.source_ip   = $urandom;
            hdr.dest_ip     = $urandom;
            hdr.source_port = 16'($urandom);
            hdr.dest_port   = 16'($urandom);
            hdr.udp_length  = 16'(len + UDP_HEADER_BYTES);
            for (int i = 0; i < len; i++) begin
                payload[i] = 8'($urandom);
            end
            // length counts in the pseudo header and again in the udp header
            sum = 32'd17 + 2 * hdr.udp_length + hdr.source_port + hdr.dest_port
                + hdr.source_ip[31:16] + hdr.source_ip[15:0]
                + hdr.dest_ip[31:16] + hdr.dest_ip[15:0];
            for (int i = 0; i < len; i += 2) begin
                sum = sum + {payload[i], (i + 1 < len) ? payload[i + 1] : 8'h00};
            end
            while (sum[31:16] != 16'h0) begin
                sum = sum[15:0] + sum[31:16];
            end
            hdr.checksum = ~sum[15:0];
            exp_hdr_q.push_back(hdr);
            frame_beats[f] = (len + DATA_BYTES - 1) / DATA_BYTES;
            for (int j = 0; j < frame_beats[f]; j++) begin
                remaining = len - DATA_BYTES * j;
                for (int i = 0; i < DATA_BYTES; i++) begin
                    beat.keep[i] = i < remaining;
                    // bytes outside keep carry junk that must not reach the sum
                    beat.data[8*i +: 8] = (i < remaining) ? payload[DATA_BYTES*j + i]
                                                          : 8'($urandom);
                end
                beat.last = j == frame_beats[f] - 1;
                beat_q.push_back(beat);
            end
        end
    endtask

    task automatic offer_header(input hdr_t hdr);
        logic taken;
        in_hdr_valid   = 1'b1;
        in_source_ip   = hdr.source_ip;
        in_dest_ip     = hdr.dest_ip;
        in_source_port = hdr.source_port;
        in_dest_port   = hdr.dest_port;
        taken          = 1'b0;
        // ready comes from registers only, so it holds up to the next rising edge
        while (!taken) begin
            taken = in_hdr_ready;
            @(negedge clk);
        end
        in_hdr_valid = 1'b0;
    endtask

    task automatic drive_beat(input beat_t beat);
        logic taken;
        if ($urandom % 4 == 0) begin
            @(negedge clk);
        end
        in_tvalid = 1'b1;
        in_tdata  = beat.data;
        in_tkeep  = beat.keep;
        in_tlast  = beat.last;
        taken     = 1'b0;
        while (!taken) begin
            taken = in_tready;
            @(negedge clk);
        end
        in_tvalid = 1'b0;
    endtask

    task automatic send_frame(input int f);
        offer_header(exp_hdr_q[f]);
        for (int j = 0; j < frame_beats[f]; j++) begin
            drive_beat(beat_q[next_beat]);
            next_beat++;
        end
    endtask

    // random back-pressure on both outputs
    initial begin
        out_tready    = 1'b0;
        out_hdr_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_tready    = ($urandom % 4) != 0;
            out_hdr_ready = !hold_hdr && (($urandom % 3) != 0);
        end
    end

    // expected heads follow the output handshakes
    always @(posedge clk) begin
        if (rst) begin
            hdr_count  <= 0;
            beat_count <= 0;
            exp_hdr    <= header_at(0);
            exp_beat   <= beat_at(0);
        end else begin
            if (out_hdr_valid && out_hdr_ready) begin
                hdr_count <= hdr_count + 1;
                exp_hdr   <= header_at(hdr_count + 1);
            end
            if (out_tvalid && out_tready) begin
                beat_count <= beat_count + 1;
                exp_beat   <= beat_at(beat_count + 1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && out_hdr_ready |-> out_udp_length == exp_hdr.udp_length)
        else begin
            hdr_errors++;
            $display("CHECK FAILED at %0t: header %0d length %0d, expected %0d", $time,
                     $sampled(hdr_count), $sampled(out_udp_length),
                     $sampled(exp_hdr.udp_length));
        end

    assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && out_hdr_ready |-> out_udp_checksum == exp_hdr.checksum)
        else begin
            hdr_errors++;
            $display("CHECK FAILED at %0t: header %0d checksum %h, expected %h", $time,
                     $sampled(hdr_count), $sampled(out_udp_checksum),
                     $sampled(exp_hdr.checksum));
        end

    assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && out_hdr_ready |->
            out_source_ip == exp_hdr.source_ip && out_dest_ip == exp_hdr.dest_ip &&
            out_source_port == exp_hdr.source_port && out_dest_port == exp_hdr.dest_port)
        else begin
            hdr_errors++;
            $display("CHECK FAILED at %0t: header %0d addresses or ports differ", $time,
                     $sampled(hdr_count));
        end

    assert property (@(posedge clk) disable iff (rst)
        out_tvalid && out_tready |->
            out_tdata == exp_beat.data && out_tkeep == exp_beat.keep &&
            out_tlast == exp_beat.last)
        else begin
            beat_errors++;
            $display("CHECK FAILED at %0t: beat %0d data %h keep %b last %b, expected %h %b %b",
                     $time, $sampled(beat_count), $sampled(out_tdata), $sampled(out_tkeep),
                     $sampled(out_tlast), $sampled(exp_beat.data), $sampled(exp_beat.keep),
                     $sampled(exp_beat.last));
        end

    assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata))
        else begin
            beat_errors++;
            $display("CHECK FAILED at %0t: payload output changed while stalled", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_udp_checksum))
        else begin
            hdr_errors++;
            $display("CHECK FAILED at %0t: header output changed while stalled", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        in_tvalid && in_tready |-> busy)
        else begin
            ctrl_errors++;
            $display("CHECK FAILED at %0t: busy low while a beat is accepted", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && out_hdr_ready |-> hdr_count < NUM_FRAMES)
        else begin
            ctrl_errors++;
            $display("the DUT sent more headers than frames were sent");
        end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(17));
        rst            = 1'b1;
        in_hdr_valid   = 1'b0;
        in_source_ip   = '0;
        in_dest_ip     = '0;
        in_source_port = '0;
        in_dest_port   = '0;
        in_tdata       = '0;
        in_tkeep       = '0;
        in_tvalid      = 1'b0;
        in_tlast       = 1'b0;
        build_frames();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (!out_hdr_valid && !out_tvalid && !in_tready && !busy && !in_hdr_ready)
            else begin
                ctrl_errors++;
                $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
            end
        for (int f = 0; f < HOLD_FIRST; f++) begin
            send_frame(f);
        end
        // start the stalled run from an empty header FIFO
        while (hdr_count < HOLD_FIRST) begin
            @(negedge clk);
        end
        hold_hdr = 1'b1;
        @(negedge clk);
        for (int f = HOLD_FIRST; f < HOLD_FIRST + HDR_CAPACITY; f++) begin
            send_frame(f);
        end
        while (busy) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (!in_hdr_ready && out_hdr_valid && hdr_count == HOLD_FIRST)
            else begin
                ctrl_errors++;
                $display("CHECK FAILED at %0t: header ready %b with a full header FIFO",
                         $time, in_hdr_ready);
            end
        hold_hdr = 1'b0;
        for (int f = HOLD_FIRST + HDR_CAPACITY; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        while (hdr_count < NUM_FRAMES || beat_count < beat_q.size()) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        assert (!out_hdr_valid && !out_tvalid)
            else begin
                ctrl_errors++;
                $display("the DUT still holds output after all frames were received");
            end
        $display("errors: header %0d, payload %0d, control %0d",
                 hdr_errors, beat_errors, ctrl_errors);
        if (hdr_errors + beat_errors + ctrl_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/udp_pkg.sv
design/udp_ifs.sv
design/udp_lane_sum.sv
design/udp_checksum_fold.sv
design/udp_frame_ctrl.sv
design/udp_header_fifo.sv
design/udp_payload_fifo.sv
design/udp_checksum_top.sv
testbench/tb_udp_checksum.sv

// ==== Makefile ====
# Verilator build and run of the UDP checksum testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_checksum
FLAGS     ?= --binary --assert --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
